// File: include/mvu_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU lane parameters
// Sizes, field widths and pipeline depths
// Precision and length fields hold value-1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MVU_PARAMS_SVH
`define MVU_PARAMS_SVH

// Array geometry and memories
`define MVU_N       4           // Rows and columns of the weight matrix
`define MVU_WDEPTH  16          // Weight memory words, one bit plane each
`define MVU_DDEPTH  64          // Data memory words, one bit plane each

// Configuration field widths
`define MVU_BPREC   2           // Precision field, 1 to 4 bits
`define MVU_BLEN    4           // Vector count field
`define MVU_BQSH    4           // Quantizer right shift

// Datapath widths
`define MVU_BACC    16          // Row accumulator
`define MVU_BOUT    8           // Quantized row

// Pipeline
`define MVU_RDLAT   1           // Memory read latency
`define MVU_VVPLAT  1           // VVP register stages

`endif

// File: source/mvu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU lane types
// Vectors, job configuration, term control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mvu_params.svh"

package mvu_pkg;

    typedef logic [`MVU_N-1:0]                  dword_t;    // Bit c belongs to x[c]
    typedef logic [`MVU_N*`MVU_N-1:0]           wword_t;    // Bit r*N+c belongs to W[r][c]
    typedef logic [$clog2(`MVU_DDEPTH)-1:0]     daddr_t;
    typedef logic [$clog2(`MVU_WDEPTH)-1:0]     waddr_t;
    typedef logic [`MVU_BPREC-1:0]              prec_t;     // Precision minus one
    typedef logic [`MVU_BLEN-1:0]               len_t;      // Vector count minus one
    typedef logic [`MVU_BQSH-1:0]               qsh_t;
    typedef logic [`MVU_BPREC:0]                tshift_t;   // Bit weight j+k
    typedef logic [$clog2(`MVU_N+1)-1:0]        psum_t;     // Holds 0..N
    typedef logic signed [`MVU_BACC-1:0]        acc_t;
    typedef logic signed [`MVU_BOUT-1:0]        qout_t;

    typedef psum_t [`MVU_N-1:0] psum_vec_t;
    typedef acc_t  [`MVU_N-1:0] acc_vec_t;
    typedef qout_t [`MVU_N-1:0] result_t;

    typedef struct packed {
        prec_t   iprec;                                     // Data precision minus one
        prec_t   wprec;                                     // Weight precision minus one
        logic    d_signed;
        logic    w_signed;
        daddr_t  ibase;                                     // First data plane of vector 0
        waddr_t  wbase;                                     // Weight plane 0
        len_t    length;                                    // Vectors minus one
        qsh_t    qshift;
    } mvu_cfg_t;

    typedef struct packed {
        logic    valid;
        logic    first;                                     // Restart accumulation
        logic    last;                                      // Vector complete
        logic    neg;                                       // Sign plane product
        tshift_t shift;
    } term_t;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} ctrl_state_t;

endpackage

// File: source/mvu_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit plane memory
// One write port, one stalling read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mvu_ram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_word,
    input  logic                     step,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_word
);

    logic [WIDTH-1:0] mem [DEPTH];                          // Storage array

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;                        // Host load, no handshake
        end
    end

    // Read register holds while the pipeline is frozen
    always_ff @(posedge clk) begin
        if (step) begin
            rd_word <= mem[rd_addr];                        // Old data on same-address write
        end
    end

endmodule

// File: source/mvu_agu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU address generator
// Walks vector, weight plane and data plane
// Issues addresses and term control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_agu import mvu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     step,
    input  logic     agu_start,
    input  mvu_cfg_t cfg,
    output daddr_t   daddr,
    output waddr_t   waddr,
    output term_t    issue_term
);

    localparam int BDW = $bits(daddr_t) + $bits(len_t) + 1;    // Room for overflow

    logic           active;                                 // Terms still to issue
    len_t           v_cnt;                                  // Vector index
    prec_t          j_cnt;                                  // Weight planes done
    prec_t          k_cnt;                                  // Data planes done
    prec_t          j;                                      // Weight bit, MSB first
    prec_t          k;                                      // Data bit, MSB first
    logic           k_wrap;
    logic           j_wrap;
    logic           v_wrap;
    logic [BDW-1:0] daddr_full;

    assign j      = cfg.wprec - j_cnt;
    assign k      = cfg.iprec - k_cnt;
    assign k_wrap = (k_cnt == cfg.iprec);
    assign j_wrap = (j_cnt == cfg.wprec);
    assign v_wrap = (v_cnt == cfg.length);

    // Vectors are packed contiguously, iprec+1 planes each
    assign daddr_full = BDW'(cfg.ibase) + BDW'(v_cnt) * (BDW'(cfg.iprec) + BDW'(1)) + BDW'(k);
    assign daddr      = daddr_t'(daddr_full);
    assign waddr      = cfg.wbase + waddr_t'(j);

    always_comb begin
        issue_term.valid = active;
        issue_term.first = active && (j_cnt == '0) && (k_cnt == '0);
        issue_term.last  = active && j_wrap && k_wrap;
        issue_term.neg   = (cfg.w_signed && (j_cnt == '0)) ^ (cfg.d_signed && (k_cnt == '0));
        issue_term.shift = tshift_t'(j) + tshift_t'(k);     // Plane bit weight
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            v_cnt  <= '0;
            j_cnt  <= '0;
            k_cnt  <= '0;
        end else if (agu_start) begin
            active <= 1'b1;                                 // First term next cycle
            v_cnt  <= '0;
            j_cnt  <= '0;
            k_cnt  <= '0;
        end else if (step && active) begin
            if (!k_wrap) begin
                k_cnt <= k_cnt + 1'b1;                      // Inner loop over data planes
            end else begin
                k_cnt <= '0;
                if (!j_wrap) begin
                    j_cnt <= j_cnt + 1'b1;
                end else begin
                    j_cnt <= '0;
                    if (v_wrap) begin
                        active <= 1'b0;                     // Job fully issued
                    end else begin
                        v_cnt <= v_cnt + 1'b1;              // Next vector while this drains
                    end
                end
            end
        end
    end

    // Configured vectors must fit in data memory
    assert property (@(posedge clk) disable iff (!rst_n)
        active |-> (daddr_full < BDW'(`MVU_DDEPTH)))
        else $error("data address beyond memory depth");

endmodule

// File: source/mvu_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU job controller
// Job FSM, config latch, pipeline step
// Term delay line, done and irq
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_controller import mvu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     job_valid,
    output logic     job_ready,
    input  mvu_cfg_t job_cfg,
    input  logic     res_valid,
    input  logic     res_ready,
    input  term_t    issue_term,
    output logic     agu_start,
    output mvu_cfg_t cfg_q,
    output logic     step,
    output term_t    acc_term,
    output logic     done,
    output logic     irq
);

    localparam int DLY = `MVU_RDLAT + `MVU_VVPLAT;          // Memory plus VVP stages

    ctrl_state_t state;
    len_t        res_cnt;                                   // Results accepted so far
    term_t       dly_q [DLY];
    logic        accept;
    logic        res_take;
    logic        last_take;

    assign job_ready = (state == IDLE);
    assign accept    = job_valid && job_ready;
    assign agu_start = accept;
    assign step      = !(res_valid && !res_ready);         // Freeze on output stall
    assign res_take  = res_valid && res_ready && (state != IDLE);
    assign last_take = res_take && (res_cnt == cfg_q.length);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            cfg_q   <= '0;
            res_cnt <= '0;
            done    <= 1'b0;
            irq     <= 1'b0;
        end else begin
            done <= last_take;                              // One pulse after final accept
            if (accept) begin
                cfg_q   <= job_cfg;
                res_cnt <= '0;
                irq     <= 1'b0;
            end else begin
                if (res_take) begin
                    res_cnt <= res_cnt + 1'b1;
                end
                if (last_take) begin
                    irq <= 1'b1;                            // Held until next job
                end
            end
            case (state)
                IDLE:    if (accept) state <= RUN;
                RUN:     if (step && !issue_term.valid) state <= DRAIN;
                DRAIN:   if (last_take) state <= IDLE;     // Results trail the last term
                default: state <= IDLE;
            endcase
        end
    end

    // Align term control with psum out of the VVP
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                dly_q[i] <= '0;
            end
        end else if (step) begin
            dly_q[0] <= issue_term;
            for (int i = 1; i < DLY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign acc_term = dly_q[DLY-1];

    // Ready for a new job only once no term or result of the old one is in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        job_ready |-> !(issue_term.valid || res_valid))
        else $error("job_ready high while a job runs");

endmodule

// File: source/mvu_vvp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit plane vector-vector product
// AND and popcount for every matrix row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_vvp import mvu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    input  wword_t    wword,
    input  dword_t    dword,
    output psum_vec_t psum
);

    localparam int N = `MVU_N;

    // Count of set bits in one row
    function automatic psum_t popcount(input dword_t bits);
        psum_t cnt;
        cnt = '0;
        for (int c = 0; c < N; c++) begin
            cnt = cnt + psum_t'(bits[c]);
        end
        return cnt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            psum <= '0;
        end else if (step) begin
            for (int r = 0; r < N; r++) begin
                psum[r] <= popcount(wword[r*N +: N] & dword);   // Row r against x plane
            end
        end
    end

endmodule

// File: source/mvu_shacc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shift accumulator
// Weights each psum by 2^(j+k), signs it
// Hands off the finished vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_shacc import mvu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    input  term_t     term,
    input  psum_vec_t psum,
    output logic      sum_valid,
    output acc_vec_t  sum
);

    acc_vec_t acc;                                          // Running row sums
    acc_vec_t acc_nxt;

    always_comb begin
        acc_t contrib;
        acc_t base;
        for (int r = 0; r < `MVU_N; r++) begin
            contrib = acc_t'(psum[r]) <<< term.shift;
            if (term.neg) begin
                contrib = -contrib;                         // Sign plane has weight -2^b
            end
            base       = term.first ? acc_t'(0) : acc[r];
            acc_nxt[r] = base + contrib;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc       <= '0;
            sum       <= '0;
            sum_valid <= 1'b0;
        end else if (step) begin
            sum_valid <= term.valid && term.last;
            if (term.valid) begin
                acc <= acc_nxt;
                if (term.last) begin
                    sum <= acc_nxt;                         // Total for the quantizer
                end
            end
        end
    end

endmodule

// File: source/mvu_quant.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output quantizer
// Arithmetic shift and saturate per row
// Drives the valid/ready result stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_quant import mvu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     step,
    input  qsh_t     qshift,
    input  logic     sum_valid,
    input  acc_vec_t sum,
    output logic     res_valid,
    input  logic     res_ready,
    output result_t  res_data
);

    localparam acc_t QMAX = acc_t'(2 ** (`MVU_BOUT - 1) - 1);  // +127
    localparam acc_t QMIN = acc_t'(-(2 ** (`MVU_BOUT - 1)));   // -128

    result_t q;

    always_comb begin
        acc_t sh;
        for (int r = 0; r < `MVU_N; r++) begin
            sh = $signed(sum[r]) >>> qshift;
            if (sh > QMAX) begin
                q[r] = qout_t'(QMAX);                       // Clip high
            end else if (sh < QMIN) begin
                q[r] = qout_t'(QMIN);                       // Clip low
            end else begin
                q[r] = qout_t'(sh);
            end
        end
    end

    // Step is low only while a result waits, so the register holds it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_data  <= '0;
        end else if (step) begin
            res_valid <= sum_valid;
            if (sum_valid) begin
                res_data <= q;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data)))
        else $error("result changed while stalled");

endmodule

// File: source/mvu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU lane top level
// Controller, AGU, memories and datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module mvu_top import mvu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     job_valid,
    output logic     job_ready,
    input  mvu_cfg_t job_cfg,
    input  logic     wrw_en,
    input  waddr_t   wrw_addr,
    input  wword_t   wrw_word,
    input  logic     wrd_en,
    input  daddr_t   wrd_addr,
    input  dword_t   wrd_word,
    output logic     res_valid,
    input  logic     res_ready,
    output result_t  res_data,
    output logic     done,
    output logic     irq
);

    mvu_cfg_t  cfg_q;                                       // Latched job
    term_t     issue_term;                                  // From AGU
    term_t     acc_term;                                    // Aligned with psum
    logic      agu_start;
    logic      step;                                        // Global pipeline enable
    daddr_t    rd_daddr;
    waddr_t    rd_waddr;
    wword_t    rd_wword;
    dword_t    rd_dword;
    psum_vec_t psum;
    logic      sum_valid;
    acc_vec_t  sum;

    mvu_controller u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .job_valid  (job_valid),
        .job_ready  (job_ready),
        .job_cfg    (job_cfg),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .issue_term (issue_term),
        .agu_start  (agu_start),
        .cfg_q      (cfg_q),
        .step       (step),
        .acc_term   (acc_term),
        .done       (done),
        .irq        (irq)
    );

    mvu_agu u_agu (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (step),
        .agu_start  (agu_start),
        .cfg        (cfg_q),
        .daddr      (rd_daddr),
        .waddr      (rd_waddr),
        .issue_term (issue_term)
    );

    mvu_ram #(.WIDTH($bits(wword_t)), .DEPTH(`MVU_WDEPTH)) u_wram (
        .clk     (clk),
        .wr_en   (wrw_en),
        .wr_addr (wrw_addr),
        .wr_word (wrw_word),
        .step    (step),
        .rd_addr (rd_waddr),
        .rd_word (rd_wword)
    );

    mvu_ram #(.WIDTH($bits(dword_t)), .DEPTH(`MVU_DDEPTH)) u_dram (
        .clk     (clk),
        .wr_en   (wrd_en),
        .wr_addr (wrd_addr),
        .wr_word (wrd_word),
        .step    (step),
        .rd_addr (rd_daddr),
        .rd_word (rd_dword)
    );

    mvu_vvp u_vvp (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step),
        .wword (rd_wword),
        .dword (rd_dword),
        .psum  (psum)
    );

    mvu_shacc u_shacc (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .term      (acc_term),
        .psum      (psum),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    mvu_quant u_quant (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .qshift    (cfg_q.qshift),
        .sum_valid (sum_valid),
        .sum       (sum),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

endmodule

// File: bench/tb_mvu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MVU lane testbench
// Reference model, random back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "mvu_params.svh"

module tb_mvu_top import mvu_pkg::*; ();

    localparam int N       = `MVU_N;
    localparam int TIMEOUT = 5000;                          // Cycles allowed per wait
    localparam int NJOBS   = 5;
    localparam int QMAX    = (1 << (`MVU_BOUT - 1)) - 1;
    localparam int QMIN    = -(1 << (`MVU_BOUT - 1));

    logic clk, rst_n, job_valid, job_ready, wrw_en, wrd_en;
    logic res_valid, res_ready, done, irq;
    mvu_cfg_t job_cfg;
    waddr_t   wrw_addr;
    wword_t   wrw_word;
    daddr_t   wrd_addr;
    dword_t   wrd_word;
    result_t  res_data;

    wword_t      wmem [`MVU_WDEPTH];                        // Copies of what was written
    dword_t      dmem [`MVU_DDEPTH];
    result_t     exp_q [$];                                 // Expected vectors in order
    result_t     exp_head;
    result_t     prev_data;
    mvu_cfg_t    jobs [NJOBS];
    logic [31:0] rng;
    logic        rand_ready;
    logic        busy;                                      // Job accepted, no done yet
    logic        irq_hold;                                  // done seen, next job not yet
    logic        prev_stall;
    logic        timed_out;                                 // A wait ran out of cycles
    int          err_cnt, res_cnt, done_cnt;

    mvu_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic mvu_cfg_t make_cfg(input int ip, input int wp, input int ds,
                                          input int ws, input int ib, input int wb,
                                          input int len, input int qs);
        mvu_cfg_t c;
        c.iprec    = prec_t'(ip);                           // Stored as bits minus one
        c.wprec    = prec_t'(wp);
        c.d_signed = (ds != 0);
        c.w_signed = (ws != 0);
        c.ibase    = daddr_t'(ib);
        c.wbase    = waddr_t'(wb);
        c.length   = len_t'(len);
        c.qshift   = qsh_t'(qs);
        return c;
    endfunction

    // Row r = sum over c of W[r][c] * x[c], then shift and clip
    function automatic result_t ref_vector(input mvu_cfg_t cfg, input int v);
        result_t res;
        int      w, x, acc, sh, wp, ip, dbase;
        wp    = int'(cfg.wprec);
        ip    = int'(cfg.iprec);
        dbase = int'(cfg.ibase) + v * (ip + 1);             // Vectors packed back to back
        for (int r = 0; r < N; r++) begin
            acc = 0;
            for (int c = 0; c < N; c++) begin
                w = 0;
                x = 0;
                for (int j = 0; j <= wp; j++) begin
                    if (wmem[int'(cfg.wbase) + j][r*N + c])
                        w += (cfg.w_signed && j == wp) ? -(1 << j) : (1 << j);
                end
                for (int k = 0; k <= ip; k++) begin
                    if (dmem[dbase + k][c])
                        x += (cfg.d_signed && k == ip) ? -(1 << k) : (1 << k);
                end
                acc += w * x;
            end
            sh = acc >>> cfg.qshift;
            sh = (sh > QMAX) ? QMAX : (sh < QMIN) ? QMIN : sh;
            res[r] = qout_t'(sh);
        end
        return res;
    endfunction

    task automatic note_timeout(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        timed_out = 1'b1;
    endtask

    // Weight 11..15 all ones gives an all-15 matrix at 12 and all -8 at 8; data 48..63 all ones
    task automatic load_memories();
        for (int a = 0; a < `MVU_DDEPTH; a++) begin
            @(posedge clk);
            rng      = xorshift(rng);
            dmem[a]  = (a >= 48) ? '1 : dword_t'(rng);
            wrd_en   <= 1'b1;
            wrd_addr <= daddr_t'(a);
            wrd_word <= dmem[a];
            wrw_en   <= (a < `MVU_WDEPTH);
            if (a < `MVU_WDEPTH) begin
                rng      = xorshift(rng);
                wmem[a]  = (a >= 11) ? '1 : (a >= 8) ? '0 : wword_t'(rng);
                wrw_addr <= waddr_t'(a);
                wrw_word <= wmem[a];
            end
        end
        @(posedge clk);
        wrd_en <= 1'b0;
        wrw_en <= 1'b0;
    endtask

    task automatic run_job(input mvu_cfg_t cfg);
        int n, d0, r0;
        d0 = done_cnt;
        r0 = res_cnt;
        for (int v = 0; v <= int'(cfg.length); v++) exp_q.push_back(ref_vector(cfg, v));
        @(posedge clk);
        job_valid <= 1'b1;
        job_cfg   <= cfg;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!job_ready && n < TIMEOUT);
        job_valid <= 1'b0;
        if (!job_ready) begin
            note_timeout("job acceptance");
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!done && n < TIMEOUT);
        if (!done) begin
            note_timeout("done pulse");
            return;
        end
        repeat (3) @(posedge clk);                          // irq must outlive the pulse
        if (done_cnt != d0 + 1 || res_cnt != r0 + int'(cfg.length) + 1 || !irq) begin
            $display("Error at %0t: job ended with %0d done pulses, %0d results, irq %b",
                     $time, done_cnt - d0, res_cnt - r0, irq);
            err_cnt++;
        end
    endtask

    always @(posedge clk) begin                             // Random back-pressure
        if (rand_ready) begin
            rng = xorshift(rng);
            res_ready <= (rng[7:0] > 8'd90);
        end else begin
            res_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_stall && (!res_valid || res_data !== prev_data)) begin
                $display("Mismatch at %0t: stalled result moved from %h to %h", $time,
                         prev_data, res_data);
                err_cnt++;
            end
            if (res_valid && res_ready) begin
                res_cnt++;
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: result %h arrived with none expected", $time,
                             res_data);
                    err_cnt++;
                end else begin
                    exp_head = exp_q.pop_front();
                    if (res_data !== exp_head) begin
                        $display("Mismatch at %0t: result %h, expected %h", $time,
                                 res_data, exp_head);
                        err_cnt++;
                    end
                end
            end
            if (done) begin
                done_cnt++;
                if (!busy || !irq || exp_q.size() != 0) begin
                    $display("Error at %0t: done with busy %b, irq %b, %0d results left",
                             $time, busy, irq, exp_q.size());
                    err_cnt++;
                end
                busy     = 1'b0;
                irq_hold = 1'b1;
            end else if ((busy && (job_ready || irq)) || (irq_hold && !irq)) begin
                $display("Error at %0t: job_ready %b or irq %b wrong for the job phase",
                         $time, job_ready, irq);
                err_cnt++;
            end
            if (job_valid && job_ready) begin
                busy     = 1'b1;
                irq_hold = 1'b0;                            // irq clears on acceptance
            end
            prev_stall = res_valid && !res_ready;
            prev_data  = res_data;
        end
    end

    initial begin
        {rst_n, job_valid, wrw_en, wrd_en, rand_ready, busy, irq_hold, prev_stall} = '0;
        timed_out = 1'b0;
        res_ready = 1'b1;
        job_cfg   = '0;
        {wrw_addr, wrw_word, wrd_addr, wrd_word, prev_data} = '0;
        {err_cnt, res_cnt, done_cnt} = '0;
        rng     = 32'd31;
        jobs[0] = make_cfg(1, 1, 0, 0, 0, 0, 3, 0);         // Unsigned 2x2 bit, 4 vectors
        jobs[1] = make_cfg(1, 3, 1, 1, 8, 2, 5, 1);         // Signed, mixed precision
        jobs[2] = make_cfg(2, 1, 1, 0, 20, 5, 7, 0);        // Signed data only
        jobs[3] = make_cfg(3, 3, 0, 0, 48, 12, 3, 0);       // Clips high
        jobs[4] = make_cfg(3, 3, 0, 1, 48, 8, 3, 0);        // Clips low
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (res_valid || done || irq || !job_ready) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            err_cnt++;
        end
        load_memories();
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            @(negedge clk);
            rand_ready = (pass == 1);                       // Second round with stalls
            for (int i = 0; i < NJOBS && !timed_out; i++) begin
                run_job(jobs[i]);
            end
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d, results: %0d, done pulses: %0d", err_cnt, res_cnt, done_cnt);
        if (err_cnt == 0 && exp_q.size() == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
source/mvu_pkg.sv
source/mvu_ram.sv
source/mvu_agu.sv
source/mvu_controller.sv
source/mvu_vvp.sv
source/mvu_shacc.sv
source/mvu_quant.sv
source/mvu_top.sv
bench/tb_mvu_top.sv

// File: Makefile
# Verilator build and run of the MVU lane testbench

VERILATOR ?= verilator
TOP       ?= tb_mvu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
